//--- ecc_code_pkg.sv
`default_nettype none

package ecc_code_pkg;

    localparam int DATA_WIDTH   = 38;
    localparam int PARITY_WIDTH = 7; // six hamming bits plus one overall bit

    typedef logic [DATA_WIDTH-1:0]   data_t;
    typedef logic [PARITY_WIDTH-1:0] parity_t;
    typedef logic [PARITY_WIDTH-1:0] syndrome_t; // stored parity xor recomputed parity

    // every data column has odd weight so a double flip always gives an even syndrome
    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11] ^ d[13] ^ d[15]
             ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25] ^ d[26] ^ d[28] ^ d[30] ^ d[32]
             ^ d[34] ^ d[36];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12] ^ d[13] ^ d[16]
             ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25] ^ d[27] ^ d[28] ^ d[31] ^ d[32]
             ^ d[35] ^ d[36];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14] ^ d[15] ^ d[16]
             ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[29] ^ d[30] ^ d[31] ^ d[32]
             ^ d[37];
        p[3] = d[4] ^ d[5] ^ d[6] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[18] ^ d[19] ^ d[20]
             ^ d[21] ^ d[22] ^ d[23] ^ d[24] ^ d[25] ^ d[33] ^ d[34] ^ d[35] ^ d[36]
             ^ d[37];
        p[4] = ^d[25:11];
        p[5] = ^d[37:26];
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11] ^ d[12] ^ d[14]
             ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24] ^ d[26] ^ d[27] ^ d[29] ^ d[32]
             ^ d[33] ^ d[36];
        return p;
    endfunction

endpackage

`default_nettype wire

//--- ecc_mem_pkg.sv
`default_nettype none

package ecc_mem_pkg;

    import ecc_code_pkg::*;

    localparam int ADDR_WIDTH = 6;
    localparam int MEM_DEPTH  = 2 ** ADDR_WIDTH;
    localparam int CODE_WIDTH = DATA_WIDTH + PARITY_WIDTH; // parity sits above the data

    typedef logic [ADDR_WIDTH-1:0] addr_t;
    typedef logic [CODE_WIDTH-1:0] code_t;
    typedef logic [15:0]           count_t;

    localparam count_t COUNT_MAX = '1; // counters stick here

endpackage

`default_nettype wire

//--- ecc_38_cal.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_38_cal
    import ecc_code_pkg::*;
(
    input  data_t   data_in,
    input  parity_t parity_in,
    input  logic    bypass,
    output data_t   data_out,
    output logic    sbit_err,
    output logic    dbit_err
);

    syndrome_t syndrome;
    data_t     mask;    // one-hot flip for a bad data bit
    logic      chk_err; // single error confined to the check bits
    logic      dbl_err;

    assign syndrome = parity_in ^ ecc_encode(data_in);

    always_comb begin
        mask    = '0;
        chk_err = 1'b0;
        dbl_err = 1'b0;
        case (syndrome)
            7'b0000000: mask = '0; // clean word
            7'b1000011: mask[0]  = 1'b1;
            7'b1000101: mask[1]  = 1'b1;
            7'b1000110: mask[2]  = 1'b1;
            7'b0000111: mask[3]  = 1'b1;
            7'b1001001: mask[4]  = 1'b1;
            7'b1001010: mask[5]  = 1'b1;
            7'b0001011: mask[6]  = 1'b1;
            7'b1001100: mask[7]  = 1'b1;
            7'b0001101: mask[8]  = 1'b1;
            7'b0001110: mask[9]  = 1'b1;
            7'b1001111: mask[10] = 1'b1;
            7'b1010001: mask[11] = 1'b1;
            7'b1010010: mask[12] = 1'b1;
            7'b0010011: mask[13] = 1'b1;
            7'b1010100: mask[14] = 1'b1;
            7'b0010101: mask[15] = 1'b1;
            7'b0010110: mask[16] = 1'b1;
            7'b1010111: mask[17] = 1'b1;
            7'b1011000: mask[18] = 1'b1;
            7'b0011001: mask[19] = 1'b1;
            7'b0011010: mask[20] = 1'b1;
            7'b1011011: mask[21] = 1'b1;
            7'b0011100: mask[22] = 1'b1;
            7'b1011101: mask[23] = 1'b1;
            7'b1011110: mask[24] = 1'b1;
            7'b0011111: mask[25] = 1'b1;
            7'b1100001: mask[26] = 1'b1;
            7'b1100010: mask[27] = 1'b1;
            7'b0100011: mask[28] = 1'b1;
            7'b1100100: mask[29] = 1'b1;
            7'b0100101: mask[30] = 1'b1;
            7'b0100110: mask[31] = 1'b1;
            7'b1100111: mask[32] = 1'b1;
            7'b1101000: mask[33] = 1'b1;
            7'b0101001: mask[34] = 1'b1;
            7'b0101010: mask[35] = 1'b1;
            7'b1101011: mask[36] = 1'b1;
            7'b0101100: mask[37] = 1'b1;
            7'b1000000,
            7'b0100000,
            7'b0010000,
            7'b0001000,
            7'b0000100,
            7'b0000010,
            7'b0000001: chk_err = 1'b1; // data is intact, only a check bit flipped
            default:    dbl_err = 1'b1; // even weight or unused code
        endcase
    end

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : ((|mask) | chk_err);
    assign dbit_err = bypass ? 1'b0 : dbl_err;

endmodule

`default_nettype wire

//--- ecc_mem_array.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_mem_array
    import ecc_code_pkg::*;
    import ecc_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  we,
    input  addr_t waddr,
    input  data_t wdata,
    input  code_t inject,
    input  logic  re,
    input  addr_t raddr,
    output logic  arr_valid,
    output addr_t arr_addr,
    output code_t arr_code
);

    code_t mem [MEM_DEPTH];
    code_t wr_code;

    // inject flips chosen codeword bits after encoding
    assign wr_code = {ecc_encode(wdata), wdata} ^ inject;

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wr_code;
        end
    end

    // a read that hits the word being written sees the old value
    always_ff @(posedge clk) begin
        if (re) begin
            arr_code <= mem[raddr];
            arr_addr <= raddr;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            arr_valid <= 1'b0;
        end else begin
            arr_valid <= re;
        end
    end

endmodule

`default_nettype wire

//--- ecc_read_path.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_read_path
    import ecc_code_pkg::*;
    import ecc_mem_pkg::*;
(
    input  logic  clk,
    input  logic  reset,
    input  logic  arr_valid,
    input  addr_t arr_addr,
    input  code_t arr_code,
    input  logic  bypass,
    output logic  rvalid,
    output data_t rdata,
    output logic  sbit_err,
    output logic  dbit_err,
    output addr_t rd_addr
);

    data_t   code_data;
    parity_t code_parity;
    data_t   cal_data;
    logic    cal_sbit;
    logic    cal_dbit;

    assign code_data   = arr_code[DATA_WIDTH-1:0];
    assign code_parity = arr_code[CODE_WIDTH-1:DATA_WIDTH];

    ecc_38_cal u_cal (
        .data_in   (code_data),
        .parity_in (code_parity),
        .bypass    (bypass),
        .data_out  (cal_data),
        .sbit_err  (cal_sbit),
        .dbit_err  (cal_dbit)
    );

    always_ff @(posedge clk) begin
        if (reset) begin
            rvalid   <= 1'b0;
            sbit_err <= 1'b0;
            dbit_err <= 1'b0;
        end else begin
            rvalid   <= arr_valid;
            sbit_err <= arr_valid & cal_sbit; // flags only mean something with a valid word
            dbit_err <= arr_valid & cal_dbit;
        end
    end

    always_ff @(posedge clk) begin
        rdata   <= cal_data;
        rd_addr <= arr_addr;
    end

endmodule

`default_nettype wire

//--- ecc_err_log.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_err_log
    import ecc_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   rvalid,
    input  logic   sbit_err,
    input  logic   dbit_err,
    input  addr_t  rd_addr,
    input  logic   err_clear,
    output count_t sbit_count,
    output count_t dbit_count,
    output logic   err_valid,
    output addr_t  err_addr,
    output logic   err_is_dbit
);

    logic sbit_hit;
    logic dbit_hit;
    logic capture;

    assign sbit_hit = rvalid & sbit_err;
    assign dbit_hit = rvalid & dbit_err;

    // only the first error since reset or clear is recorded
    assign capture = (sbit_hit | dbit_hit) & ~err_valid & ~err_clear;

    always_ff @(posedge clk) begin
        if (reset || err_clear) begin
            sbit_count <= '0;
            dbit_count <= '0;
        end else begin
            if (sbit_hit && sbit_count != COUNT_MAX) begin
                sbit_count <= sbit_count + 1'b1;
            end
            if (dbit_hit && dbit_count != COUNT_MAX) begin
                dbit_count <= dbit_count + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset || err_clear) begin
            err_valid <= 1'b0; // clear beats a flag arriving in the same cycle
        end else if (capture) begin
            err_valid <= 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            err_addr    <= rd_addr;
            err_is_dbit <= dbit_err;
        end
    end

endmodule

`default_nettype wire

//--- ecc_mem_top.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_mem_top
    import ecc_code_pkg::*;
    import ecc_mem_pkg::*;
(
    input  logic   clk,
    input  logic   reset,
    input  logic   we,
    input  addr_t  waddr,
    input  data_t  wdata,
    input  code_t  inject,
    input  logic   re,
    input  addr_t  raddr,
    input  logic   bypass,
    output logic   rvalid,
    output data_t  rdata,
    output logic   sbit_err,
    output logic   dbit_err,
    input  logic   err_clear,
    output count_t sbit_count,
    output count_t dbit_count,
    output logic   err_valid,
    output addr_t  err_addr,
    output logic   err_is_dbit
);

    logic  arr_valid;
    addr_t arr_addr;
    code_t arr_code;
    addr_t rd_addr; // address of the word now on rdata

    ecc_mem_array u_array (
        .clk       (clk),
        .reset     (reset),
        .we        (we),
        .waddr     (waddr),
        .wdata     (wdata),
        .inject    (inject),
        .re        (re),
        .raddr     (raddr),
        .arr_valid (arr_valid),
        .arr_addr  (arr_addr),
        .arr_code  (arr_code)
    );

    ecc_read_path u_read_path (
        .clk       (clk),
        .reset     (reset),
        .arr_valid (arr_valid),
        .arr_addr  (arr_addr),
        .arr_code  (arr_code),
        .bypass    (bypass),
        .rvalid    (rvalid),
        .rdata     (rdata),
        .sbit_err  (sbit_err),
        .dbit_err  (dbit_err),
        .rd_addr   (rd_addr)
    );

    ecc_err_log u_err_log (
        .clk         (clk),
        .reset       (reset),
        .rvalid      (rvalid),
        .sbit_err    (sbit_err),
        .dbit_err    (dbit_err),
        .rd_addr     (rd_addr),
        .err_clear   (err_clear),
        .sbit_count  (sbit_count),
        .dbit_count  (dbit_count),
        .err_valid   (err_valid),
        .err_addr    (err_addr),
        .err_is_dbit (err_is_dbit)
    );

endmodule

`default_nettype wire

//--- ecc_mem_tb.sv
`timescale 1ns/10ps
`default_nettype none

module ecc_mem_tb
    import ecc_code_pkg::*;
    import ecc_mem_pkg::*;
();

    localparam int CLK_HALF        = 4;
    localparam int RESET_CYCLES    = 10;
    localparam int NUM_OPS         = 2 * MEM_DEPTH + 2 * 32 + 16 + 3 * 2 + 2;
    localparam int WATCHDOG_CYCLES = NUM_OPS * 4 + RESET_CYCLES + 100;

    typedef struct packed {
        addr_t addr;
        data_t data;
        logic  check_data;
        logic  sbit;
        logic  dbit;
    } read_exp_t;

    logic   clk = 1'b0;
    logic   reset;
    logic   we;
    addr_t  waddr;
    data_t  wdata;
    code_t  inject;
    logic   re;
    addr_t  raddr;
    logic   bypass;
    logic   err_clear;
    logic   rvalid;
    data_t  rdata;
    logic   sbit_err;
    logic   dbit_err;
    count_t sbit_count;
    count_t dbit_count;
    logic   err_valid;
    addr_t  err_addr;
    logic   err_is_dbit;

    data_t       model_data [MEM_DEPTH];
    code_t       model_inj  [MEM_DEPTH]; // flip mask applied on the last write
    read_exp_t   exp_q [$];
    read_exp_t   issue_exp; // expectation for the read presented this cycle
    read_exp_t   head;
    count_t      model_sbit;
    count_t      model_dbit;
    logic        model_err_valid;
    addr_t       model_err_addr;
    logic        model_err_dbit;
    logic [31:0] rand_state;
    int          check_errors = 0;
    int          seq_errors   = 0;
    int          flow_errors  = 0;

    ecc_mem_top DUT (.*);

    always #CLK_HALF clk = ~clk;

    function automatic logic [31:0] next_rand();
        rand_state = rand_state * 32'd1664525 + 32'd1013904223;
        return rand_state;
    endfunction

    function automatic data_t rand_data();
        logic [31:0] lo;
        logic [31:0] hi;
        lo = next_rand();
        hi = next_rand();
        return {hi[DATA_WIDTH-33:0], lo};
    endfunction

    // one flipped bit somewhere in [lo, lo+span)
    function automatic code_t one_flip(input int unsigned lo, input int unsigned span);
        int unsigned pos;
        pos = lo + next_rand() % span;
        return code_t'(1) << pos;
    endfunction

    function automatic code_t two_flips();
        int unsigned first;
        int unsigned second;
        first  = next_rand() % CODE_WIDTH;
        second = (first + 1 + next_rand() % (CODE_WIDTH - 1)) % CODE_WIDTH; // never equals first
        return (code_t'(1) << first) | (code_t'(1) << second);
    endfunction

    function automatic bit values_match(input string name, input logic [63:0] got,
                                        input logic [63:0] want);
        assert (got == want) else $display("[FAIL] %s: got %h, expected %h", name, got, want);
        return got == want;
    endfunction

    // secded rule: one flip is corrected, two flips are only detected
    function automatic read_exp_t expect_read(input addr_t addr);
        read_exp_t e;
        int        flips;
        flips        = $countones(model_inj[addr]);
        e.addr       = addr;
        e.data       = model_data[addr];
        e.check_data = 1'b1;
        e.sbit       = 1'b0;
        e.dbit       = 1'b0;
        if (bypass) begin
            e.data = model_data[addr] ^ model_inj[addr][DATA_WIDTH-1:0]; // raw stored data
        end else if (flips == 1) begin
            e.sbit = 1'b1;
        end else if (flips >= 2) begin
            e.dbit       = 1'b1;
            e.check_data = 1'b0;
        end
        return e;
    endfunction

    task automatic write_word(input addr_t addr, input data_t data, input code_t flips);
        we               = 1'b1;
        waddr            = addr;
        wdata            = data;
        inject           = flips;
        model_data[addr] = data;
        model_inj[addr]  = flips;
        @(posedge clk);
        #1;
        we     = 1'b0;
        inject = '0;
    endtask

    task automatic issue_read(input addr_t addr);
        re        = 1'b1;
        raddr     = addr;
        issue_exp = expect_read(addr);
        @(posedge clk);
        #1;
        re = 1'b0;
    endtask

    // wait for every read to come back and the log to settle
    task automatic drain();
        @(posedge clk);
        while (exp_q.size() != 0) @(posedge clk);
        repeat (2) @(posedge clk);
        #1;
    endtask

    task automatic expect_counts(input count_t sbit, input count_t dbit);
        if (!values_match("sbit_count", 64'(sbit_count), 64'(sbit))) flow_errors++;
        if (!values_match("dbit_count", 64'(dbit_count), 64'(dbit))) flow_errors++;
    endtask

    task automatic expect_record(input logic valid, input addr_t addr, input logic is_dbit);
        if (!values_match("err_valid", 64'(err_valid), 64'(valid))) flow_errors++;
        if (valid) begin
            if (!values_match("err_addr", 64'(err_addr), 64'(addr))) flow_errors++;
            if (!values_match("err_is_dbit", 64'(err_is_dbit), 64'(is_dbit))) flow_errors++;
        end
    endtask

    assert property (@(posedge clk) disable iff (reset) rvalid == $past(re, 2))
        else begin
            seq_errors++;
            $display("rvalid did not follow re by exactly two cycles");
        end

    assert property (@(posedge clk) disable iff (reset) !(sbit_err && dbit_err))
        else begin
            seq_errors++;
            $display("sbit_err and dbit_err were high in the same cycle");
        end

    // outputs are sampled mid-cycle, away from the driving edge
    always @(negedge clk) begin
        if (reset) begin
            model_sbit      = '0;
            model_dbit      = '0;
            model_err_valid = 1'b0;
        end else begin
            if (!values_match("sbit_count", 64'(sbit_count), 64'(model_sbit))) check_errors++;
            if (!values_match("dbit_count", 64'(dbit_count), 64'(model_dbit))) check_errors++;
            if (!values_match("err_valid", 64'(err_valid), 64'(model_err_valid))) check_errors++;
            if (model_err_valid) begin
                if (!values_match("err_addr", 64'(err_addr), 64'(model_err_addr))) check_errors++;
                if (!values_match("err_is_dbit", 64'(err_is_dbit), 64'(model_err_dbit))) begin
                    check_errors++;
                end
            end
            if (rvalid) begin
                if (exp_q.size() == 0) begin
                    check_errors++;
                    $display("rvalid went high with no read outstanding");
                end else begin
                    head = exp_q.pop_front();
                    if (head.check_data) begin
                        if (!values_match("rdata", 64'(rdata), 64'(head.data))) check_errors++;
                    end
                    if (!values_match("sbit_err", 64'(sbit_err), 64'(head.sbit))) check_errors++;
                    if (!values_match("dbit_err", 64'(dbit_err), 64'(head.dbit))) check_errors++;
                    if (head.sbit) model_sbit = model_sbit + 16'd1;
                    if (head.dbit) model_dbit = model_dbit + 16'd1;
                    if ((head.sbit || head.dbit) && !model_err_valid) begin
                        model_err_valid = 1'b1;
                        model_err_addr  = head.addr;
                        model_err_dbit  = head.dbit;
                    end
                end
            end else begin // flags stay low between reads
                if (!values_match("sbit_err", 64'(sbit_err), 64'd0)) check_errors++;
                if (!values_match("dbit_err", 64'(dbit_err), 64'd0)) check_errors++;
            end
            if (err_clear) begin // clear drops a flag seen in the same cycle
                model_sbit      = '0;
                model_dbit      = '0;
                model_err_valid = 1'b0;
            end
            if (re) exp_q.push_back(issue_exp);
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("watchdog expired after %0d cycles before the tests ended", WATCHDOG_CYCLES);
        $display("Test failed");
        $finish;
    end

    initial begin
        int a;
        rand_state = 32'hbe14_6ecd;
        reset      = 1'b1;
        we         = 1'b0;
        waddr      = '0;
        wdata      = '0;
        inject     = '0;
        re         = 1'b0;
        raddr      = '0;
        bypass     = 1'b0;
        err_clear  = 1'b0;
        issue_exp  = '0;
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;

        for (a = 0; a < MEM_DEPTH; a++) write_word(addr_t'(a), rand_data(), '0);
        for (a = 0; a < MEM_DEPTH; a++) issue_read(addr_t'(a));
        drain();
        expect_counts(16'd0, 16'd0);
        expect_record(1'b0, '0, 1'b0);

        for (a = 0; a < 16; a++) write_word(addr_t'(a), rand_data(), one_flip(0, DATA_WIDTH));
        for (a = 0; a < 16; a++) issue_read(addr_t'(a));
        drain();
        expect_counts(16'd16, 16'd0);
        expect_record(1'b1, addr_t'(0), 1'b0);

        for (a = 16; a < 24; a++) begin
            write_word(addr_t'(a), rand_data(), one_flip(DATA_WIDTH, PARITY_WIDTH));
        end
        for (a = 16; a < 24; a++) issue_read(addr_t'(a));
        drain();
        expect_counts(16'd24, 16'd0);

        for (a = 24; a < 32; a++) write_word(addr_t'(a), rand_data(), two_flips());
        for (a = 24; a < 32; a++) issue_read(addr_t'(a));
        drain();
        expect_counts(16'd24, 16'd8);
        expect_record(1'b1, addr_t'(0), 1'b0); // first fault still wins

        bypass = 1'b1;
        for (a = 0; a < 32; a += 2) issue_read(addr_t'(a));
        drain();
        bypass = 1'b0;
        expect_counts(16'd24, 16'd8);

        err_clear = 1'b1;
        @(posedge clk);
        #1;
        err_clear = 1'b0;
        expect_counts(16'd0, 16'd0);
        expect_record(1'b0, '0, 1'b0);

        write_word(addr_t'(40), rand_data(), two_flips());
        issue_read(addr_t'(40));
        drain();
        write_word(addr_t'(41), rand_data(), one_flip(0, CODE_WIDTH));
        issue_read(addr_t'(41));
        drain();
        expect_counts(16'd1, 16'd1);
        expect_record(1'b1, addr_t'(40), 1'b1);

        write_word(addr_t'(42), rand_data(), one_flip(0, DATA_WIDTH));
        issue_read(addr_t'(42));
        @(posedge clk);
        #1;
        err_clear = 1'b1; // lands in the cycle the flagged read returns
        @(posedge clk);
        #1;
        err_clear = 1'b0;
        drain();
        expect_counts(16'd0, 16'd0);
        expect_record(1'b0, '0, 1'b0);

        $display("errors: %0d checker, %0d sequence, %0d flow",
                 check_errors, seq_errors, flow_errors);
        if (check_errors + seq_errors + flow_errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- ecc_mem.f
ecc_code_pkg.sv
ecc_mem_pkg.sv
ecc_38_cal.sv
ecc_mem_array.sv
ecc_read_path.sv
ecc_err_log.sv
ecc_mem_top.sv
ecc_mem_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 --top-module ecc_mem_tb -f ecc_mem.f -o ecc_mem_sim

out=$(./obj_dir/ecc_mem_sim)
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx "Test completed successfully"; then
    exit 0
fi
exit 1
